//--- design/ifu_pkg.sv
// Instruction fetch package with fetch widths and channel payload structs
`default_nettype none

package ifu_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  // Fetch PC width
  localparam int pc_size = 32;
  // One instruction
  localparam int instr_w = 32;
  // ITCM lane width in bits
  localparam int itcm_data_w = 64;

  //////////////////////////////////////////////////
  // Channel payloads
  //////////////////////////////////////////////////

  // Fetch request from the PC generator
  typedef struct packed {
    logic [pc_size-1:0] pc;
    // Set when this request directly follows the previous one
    logic               seq;
  } ifu_req_t;

  // Fetch response and instruction buffer entry
  typedef struct packed {
    logic [pc_size-1:0] pc;
    logic [instr_w-1:0] instr;
    logic               err;
  } ifu_rsp_t;

  // Bus command toward the ITCM
  typedef struct packed {
    logic [pc_size-1:0] addr;
  } icb_cmd_t;

  // Bus read response carrying one full lane
  typedef struct packed {
    logic [itcm_data_w-1:0] rdata;
  } icb_rsp_t;

endpackage

`default_nettype wire

//--- design/ifu_pc_gen.sv
// Fetch PC generator that restarts on a redirect and steps sequentially by 4
`timescale 1ns/1ps
`default_nettype none

module ifu_pc_gen
  import ifu_pkg::*;
(
  input  logic               clk,
  input  logic               rst,
  input  logic               fetch_en,
  input  logic               redirect_valid,
  input  logic [pc_size-1:0] redirect_pc,
  output logic               req_valid,
  input  logic               req_ready,
  output ifu_req_t           req
);

  logic [pc_size-1:0] pc_r;
  logic               first_r;
  logic               valid_r;
  logic               redir_pend_r;
  logic [pc_size-1:0] redir_pc_r;
  logic               req_hsk;
  logic               can_load;

  assign req_hsk = valid_r & req_ready;

  // Payload may only change when no request is waiting
  assign can_load = ~valid_r | req_hsk;

  //////////////////////////////////////////////////
  // PC and request valid
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_r      <= 1'b0;
      first_r      <= 1'b1;
      pc_r         <= '0;
      redir_pend_r <= 1'b0;
    end else if (can_load) begin
      redir_pend_r <= 1'b0;
      if (redirect_valid | redir_pend_r) begin
        // Restart from the new target
        pc_r    <= redirect_valid ? redirect_pc : redir_pc_r;
        first_r <= 1'b1;
      end else if (req_hsk) begin
        pc_r    <= pc_r + pc_size'(4);
        first_r <= 1'b0;
      end
      // New requests only while fetching is enabled
      valid_r <= fetch_en;
    end else if (redirect_valid) begin
      // A stalled request completes first, then the redirect applies
      redir_pend_r <= 1'b1;
    end
  end

  // Target parked until the stalled request is taken
  always_ff @(posedge clk) begin
    if (redirect_valid & ~can_load) begin
      redir_pc_r <= redirect_pc;
    end
  end

  assign req_valid = valid_r;
  assign req.pc    = pc_r;
  // first request after a redirect is never sequential
  assign req.seq   = ~first_r;

endmodule

`default_nettype wire

//--- design/ifu_ift2icb.sv
// Fetch-to-ITCM bridge with lane extraction and holdup fake responses
`timescale 1ns/1ps
`default_nettype none

module ifu_ift2icb
  import ifu_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     itcm_nohold,
  input  logic     holdup,
  input  logic     req_valid,
  output logic     req_ready,
  input  ifu_req_t req,
  output logic     cmd_valid,
  input  logic     cmd_ready,
  output icb_cmd_t cmd,
  input  logic     rsp_valid,
  output logic     rsp_ready,
  input  icb_rsp_t rsp,
  output logic     fr_valid,
  input  logic     fr_ready,
  output ifu_rsp_t fr
);

  // Idle means nothing outstanding
  localparam logic st_idle = 1'b0;
  // Out means a request was accepted and waits for its response
  localparam logic st_out  = 1'b1;

  logic                 state_r;
  logic                 state_nxt;
  logic                 sta_idle;
  logic                 sta_out;
  logic                 req_hsk;
  logic                 cmd_hsk;
  logic                 fr_hsk;
  logic                 lane_begin;
  logic                 lane_cross;
  logic                 lane_same;
  logic                 lane_holdup;
  logic                 need_0uop;
  logic                 zero_op_r;
  logic                 ready_condi;
  logic [pc_size-1:0]   pc_r;
  logic [pc_size-4:0]   last_lane_r;
  logic [instr_w-1:0]   lane_instr;

  assign sta_idle = (state_r == st_idle);
  assign sta_out  = (state_r == st_out);

  assign req_hsk = req_valid & req_ready;
  assign cmd_hsk = cmd_valid & cmd_ready;
  assign fr_hsk  = fr_valid & fr_ready;

  //////////////////////////////////////////////////
  // Shortcut decision
  //////////////////////////////////////////////////

  assign lane_begin = (req.pc[2:1] == 2'b00);
  // Instruction would straddle two lanes
  assign lane_cross = (req.pc[2:1] == 2'b11);

  // Sequential and inside the lane read last on the bus
  assign lane_same = req.seq & ~lane_begin &
                     (req.pc[pc_size-1:3] == last_lane_r);

  // ITCM output untouched since our last read
  assign lane_holdup = holdup & ~itcm_nohold;

  // No bus command for held data or for an error response
  assign need_0uop = lane_cross | (lane_same & lane_holdup);

  //////////////////////////////////////////////////
  // Request and command handshake
  //////////////////////////////////////////////////

  // Accept in idle or alongside the pending response
  assign ready_condi = sta_idle | (sta_out & fr_hsk);

  assign cmd_valid = req_valid & ready_condi & ~need_0uop;
  assign req_ready = cmd_ready & ready_condi;
  assign cmd.addr  = req.pc;

  // Bus response goes straight through to the buffer side
  assign rsp_ready = fr_ready;

  always_comb begin
    state_nxt = state_r;
    case (state_r)
      st_idle: begin
        if (req_hsk) state_nxt = st_out;
      end
      default: begin
        // Stay out when a new request rides on the response handshake
        if (fr_hsk) state_nxt = req_hsk ? st_out : st_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_r   <= st_idle;
      zero_op_r <= 1'b0;
    end else begin
      state_r <= state_nxt;
      if (req_hsk) zero_op_r <= need_0uop;
    end
  end

  // PC of the accepted request and lane of the last bus read
  always_ff @(posedge clk) begin
    if (req_hsk) pc_r <= req.pc;
    if (cmd_hsk) last_lane_r <= req.pc[pc_size-1:3];
  end

  //////////////////////////////////////////////////
  // Response
  //////////////////////////////////////////////////

  // ITCM rdata register holds the lane, so this also serves fake responses
  always_comb begin
    case (pc_r[2:1])
      2'b00:   lane_instr = rsp.rdata[31:0];
      2'b01:   lane_instr = rsp.rdata[47:16];
      2'b10:   lane_instr = rsp.rdata[63:32];
      default: lane_instr = '0;
    endcase
  end

  assign fr_valid = (sta_out & zero_op_r) | rsp_valid;
  assign fr.pc    = pc_r;
  assign fr.instr = lane_instr;
  assign fr.err   = (pc_r[2:1] == 2'b11);

endmodule

`default_nettype wire

//--- design/itcm_ctrl.sv
// ITCM with a 64-bit bus read port, a write strobe port and holdup tracking
`timescale 1ns/1ps
`default_nettype none

module itcm_ctrl
  import ifu_pkg::*;
#(
  parameter int itcm_aw = 12
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   cmd_valid,
  output logic                   cmd_ready,
  input  icb_cmd_t               cmd,
  output logic                   rsp_valid,
  input  logic                   rsp_ready,
  output icb_rsp_t               rsp,
  output logic                   holdup,
  input  logic                   wr_en,
  input  logic [itcm_aw-4:0]     wr_addr,
  input  logic [itcm_data_w-1:0] wr_data
);

  // Word index width and number of 64-bit words
  localparam int word_aw = itcm_aw - 3;
  localparam int depth   = 2 ** word_aw;

  logic [itcm_data_w-1:0] mem [depth];
  logic [itcm_data_w-1:0] rdata_r;
  logic [word_aw-1:0]     rd_idx;
  logic                   rsp_valid_r;
  logic                   holdup_r;
  logic                   cmd_hsk;
  logic                   rsp_hsk;

  //////////////////////////////////////////////////
  // Command side
  //////////////////////////////////////////////////

  // Writes own the array this cycle
  // and a held response blocks a new read
  assign cmd_ready = ~wr_en & (~rsp_valid_r | rsp_ready);

  assign cmd_hsk = cmd_valid & cmd_ready;
  assign rsp_hsk = rsp_valid_r & rsp_ready;

  // Byte address down to the lane index
  assign rd_idx = cmd.addr[itcm_aw-1:3];

  //////////////////////////////////////////////////
  // Array
  //////////////////////////////////////////////////

  // One access per cycle
  // cmd_ready already keeps reads out of write cycles
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
    if (cmd_hsk) begin
      rdata_r <= mem[rd_idx];
    end
  end

  //////////////////////////////////////////////////
  // Response and holdup
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_valid_r <= 1'b0;
    end else if (cmd_hsk) begin
      // Response one cycle after the command
      rsp_valid_r <= 1'b1;
    end else if (rsp_ready) begin
      rsp_valid_r <= 1'b0;
    end
  end

  // Holdup means rdata_r still shows the lane last read by fetch
  always_ff @(posedge clk) begin
    if (rst) begin
      holdup_r <= 1'b0;
    end else if (wr_en) begin
      // Another agent touched the port
      holdup_r <= 1'b0;
    end else if (rsp_hsk) begin
      holdup_r <= 1'b1;
    end
  end

  assign rsp_valid = rsp_valid_r;
  assign rsp.rdata = rdata_r;
  assign holdup    = holdup_r;

endmodule

`default_nettype wire

//--- design/ifu_instr_buf.sv
// Instruction buffer FIFO between the fetch response channel and decode
`timescale 1ns/1ps
`default_nettype none

module ifu_instr_buf
  import ifu_pkg::*;
#(
  parameter int buf_depth = 4
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  output logic     in_ready,
  input  ifu_rsp_t in_entry,
  output logic     out_valid,
  input  logic     out_ready,
  output ifu_rsp_t out_entry
);

  // Pointer and occupancy widths
  localparam int ptr_w = (buf_depth > 1) ? $clog2(buf_depth) : 1;
  localparam int cnt_w = $clog2(buf_depth + 1);

  ifu_rsp_t         mem [buf_depth];
  logic [ptr_w-1:0] wr_ptr_r;
  logic [ptr_w-1:0] rd_ptr_r;
  logic [cnt_w-1:0] count_r;
  logic             push;
  logic             pop;

  // Wrap at depth, which need not be a power of two
  function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
    if (p == ptr_w'(buf_depth - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  assign in_ready  = (count_r != cnt_w'(buf_depth));
  assign out_valid = (count_r != '0);

  assign push = in_valid & in_ready;
  assign pop  = out_valid & out_ready;

  //////////////////////////////////////////////////
  // Pointers and count
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) wr_ptr_r <= ptr_inc(wr_ptr_r);
      if (pop) rd_ptr_r <= ptr_inc(rd_ptr_r);
      // Simultaneous push and pop keep the count
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // Entry storage
  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr_r] <= in_entry;
  end

  assign out_entry = mem[rd_ptr_r];

endmodule

`default_nettype wire

//--- design/ifu_fetch_top.sv
// Instruction fetch top connecting PC generator, bridge, ITCM and buffer
`timescale 1ns/1ps
`default_nettype none

module ifu_fetch_top
  import ifu_pkg::*;
#(
  parameter int itcm_aw   = 12,
  parameter int buf_depth = 4
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   fetch_en,
  input  logic                   redirect_valid,
  input  logic [pc_size-1:0]     redirect_pc,
  input  logic                   itcm_nohold,
  input  logic                   itcm_wr_en,
  input  logic [itcm_aw-4:0]     itcm_wr_addr,
  input  logic [itcm_data_w-1:0] itcm_wr_data,
  output logic                   out_valid,
  input  logic                   out_ready,
  output ifu_rsp_t               out_entry
);

  // Generator to bridge
  logic     req_valid;
  logic     req_ready;
  ifu_req_t req;
  // Bridge to ITCM
  logic     cmd_valid;
  logic     cmd_ready;
  icb_cmd_t cmd;
  logic     rsp_valid;
  logic     rsp_ready;
  icb_rsp_t rsp;
  logic     holdup;
  // Bridge to buffer
  logic     fr_valid;
  logic     fr_ready;
  ifu_rsp_t fr;

  ifu_pc_gen u_pc_gen (
    .clk(clk), .rst(rst), .fetch_en(fetch_en),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
    .req_valid(req_valid), .req_ready(req_ready), .req(req)
  );

  ifu_ift2icb u_ift2icb (
    .clk(clk), .rst(rst), .itcm_nohold(itcm_nohold), .holdup(holdup),
    .req_valid(req_valid), .req_ready(req_ready), .req(req),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
    .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp),
    .fr_valid(fr_valid), .fr_ready(fr_ready), .fr(fr)
  );

  itcm_ctrl #(.itcm_aw(itcm_aw)) u_itcm (
    .clk(clk), .rst(rst),
    .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
    .rsp_valid(rsp_valid), .rsp_ready(rsp_ready), .rsp(rsp), .holdup(holdup),
    .wr_en(itcm_wr_en), .wr_addr(itcm_wr_addr), .wr_data(itcm_wr_data)
  );

  ifu_instr_buf #(.buf_depth(buf_depth)) u_instr_buf (
    .clk(clk), .rst(rst),
    .in_valid(fr_valid), .in_ready(fr_ready), .in_entry(fr),
    .out_valid(out_valid), .out_ready(out_ready), .out_entry(out_entry)
  );

endmodule

`default_nettype wire

//--- dv/fetch_sva.sv
// Bridge handshake and state assertions, bound into the fetch-to-ITCM bridge
`timescale 1ns/1ps
`default_nettype none

module fetch_sva
  import ifu_pkg::*;
(
  input logic     clk,
  input logic     rst,
  input logic     req_valid,
  input logic     req_ready,
  input ifu_req_t req,
  input logic     cmd_valid,
  input logic     cmd_ready,
  input icb_cmd_t cmd,
  input logic     rsp_valid,
  input logic     fr_valid,
  input logic     fr_ready,
  input ifu_rsp_t fr,
  input logic     state_r,
  input logic     zero_op_r
);

  // Read back by the testbench at the end of the run
  int   fail_cnt = 0;
  // Request accepted and its response not yet taken by the buffer
  logic pend_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      pend_r <= 1'b0;
    end else if (req_valid && req_ready) begin
      pend_r <= 1'b1;
    end else if (fr_valid && fr_ready) begin
      pend_r <= 1'b0;
    end
  end

  // Request held with the same payload until accepted
  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    req_valid && !req_ready |=> req_valid && $stable(req))
    else begin
      fail_cnt++;
      $error("req_valid dropped or req changed before its handshake");
    end

  // Bus command held until the ITCM takes it
  a_cmd_hold: assert property (@(posedge clk) disable iff (rst)
    cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
    else begin
      fail_cnt++;
      $error("cmd_valid dropped or cmd changed before its handshake");
    end

  // Fetch response held until the buffer takes it
  a_fr_hold: assert property (@(posedge clk) disable iff (rst)
    fr_valid && !fr_ready |=> fr_valid && $stable(fr))
    else begin
      fail_cnt++;
      $error("fr_valid dropped or fr changed before its handshake");
    end

  // Only one request in flight
  a_one_out: assert property (@(posedge clk) disable iff (rst)
    pend_r && !(fr_valid && fr_ready) |-> !cmd_valid)
    else begin
      fail_cnt++;
      $error("bus command raised while a request is still outstanding");
    end

  // Bus response and fake response are exclusive
  a_fake_excl: assert property (@(posedge clk) disable iff (rst)
    !(rsp_valid && state_r && zero_op_r))
    else begin
      fail_cnt++;
      $error("bus response and fake response valid in the same cycle");
    end

endmodule

bind ifu_ift2icb fetch_sva u_fetch_sva (
  .clk(clk), .rst(rst),
  .req_valid(req_valid), .req_ready(req_ready), .req(req),
  .cmd_valid(cmd_valid), .cmd_ready(cmd_ready), .cmd(cmd),
  .rsp_valid(rsp_valid),
  .fr_valid(fr_valid), .fr_ready(fr_ready), .fr(fr),
  .state_r(state_r), .zero_op_r(zero_op_r)
);

`default_nettype wire

//--- dv/fetch_tb.sv
// Directed testbench for the instruction fetch subsystem with an ITCM data model
`timescale 1ns/1ps
`default_nettype none

module fetch_tb
  import ifu_pkg::*;
();

  localparam int itcm_aw     = 12;
  localparam int buf_depth   = 4;
  localparam int words       = 2 ** (itcm_aw - 3);
  localparam int rst_cycles  = 8;
  // Entries over all tests are 16 + 12 + 24 + 11 + 12
  localparam int exp_entries = 75;
  // Each word write takes two cycles
  localparam int load_cycles = 2 * words + rst_cycles + 16;
  localparam int timeout_cycles = 64 * exp_entries + load_cycles;

  logic                   clk;
  logic                   rst;
  logic                   fetch_en;
  logic                   redirect_valid;
  logic [pc_size-1:0]     redirect_pc;
  logic                   itcm_nohold;
  logic                   itcm_wr_en;
  logic [itcm_aw-4:0]     itcm_wr_addr;
  logic [itcm_data_w-1:0] itcm_wr_data;
  logic                   out_valid;
  logic                   out_ready;
  ifu_rsp_t               out_entry;

  // Copy of the ITCM contents
  logic [itcm_data_w-1:0] model_mem [words];
  logic [31:0]            lfsr = 32'hdc692963;
  // Entries seen on the decode side and the last checked streams
  ifu_rsp_t               got_q[$];
  ifu_rsp_t               last_q[$];
  ifu_rsp_t               saved_q[$];
  int                     err_cnt = 0;
  int                     check_cnt = 0;
  int                     cycle_cnt = 0;
  int                     sva_fails;

  ifu_fetch_top #(.itcm_aw(itcm_aw), .buf_depth(buf_depth)) uut (
    .clk(clk), .rst(rst), .fetch_en(fetch_en),
    .redirect_valid(redirect_valid), .redirect_pc(redirect_pc),
    .itcm_nohold(itcm_nohold), .itcm_wr_en(itcm_wr_en),
    .itcm_wr_addr(itcm_wr_addr), .itcm_wr_data(itcm_wr_data),
    .out_valid(out_valid), .out_ready(out_ready), .out_entry(out_entry)
  );

  always #2 clk = ~clk;

  // Decode side handshakes sampled on the edge that performs them
  always @(posedge clk) begin
    if (!rst && out_valid && out_ready) got_q.push_back(out_entry);
  end

  //////////////////////////////////////////////////
  // Watchdog
  //////////////////////////////////////////////////

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= timeout_cycles) begin
      $display("Timeout: tests did not complete within %0d cycles", timeout_cycles);
      $display("Checks %0d, errors %0d, assertion failures %0d", check_cnt, err_cnt,
               uut.u_ift2icb.u_fetch_sva.fail_cnt);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Data model and checking
  //////////////////////////////////////////////////

  // Galois LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h80200003;
    return s >> 1;
  endfunction

  // One LFSR step per bit
  task automatic draw_word(output logic [63:0] w);
    w = '0;
    for (int b = 0; b < 64; b++) begin
      w = {w[62:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  // Halfword offset picks the 32-bit slice and offset 3 is an error
  function automatic ifu_rsp_t expect_entry(input logic [pc_size-1:0] pc);
    ifu_rsp_t    e;
    logic [63:0] lane;
    lane    = model_mem[pc[itcm_aw-1:3]];
    e.pc    = pc;
    e.err   = (pc[2:1] == 2'b11);
    e.instr = e.err ? '0 : 32'(lane >> (16 * pc[2:1]));
    return e;
  endfunction

  task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
    check_cnt++;
    if (act !== exp) begin
      err_cnt++;
      $display("[FAIL] %0t %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  // Pops every received entry and compares against the sequential stream
  task automatic check_stream(input logic [pc_size-1:0] start_pc, input int n, input string tag);
    ifu_rsp_t e;
    ifu_rsp_t x;
    check_val({tag, " entry count"}, n, got_q.size());
    last_q.delete();
    for (int i = 0; i < n && got_q.size() > 0; i++) begin
      e = got_q.pop_front();
      x = expect_entry(start_pc + pc_size'(4 * i));
      last_q.push_back(e);
      check_val($sformatf("%s out_entry.pc[%0d]", tag, i), x.pc, e.pc);
      check_val($sformatf("%s out_entry.instr[%0d]", tag, i), x.instr, e.instr);
      check_val($sformatf("%s out_entry.err[%0d]", tag, i), x.err, e.err);
    end
    got_q.delete();
  endtask

  //////////////////////////////////////////////////
  // Stimulus helpers
  //////////////////////////////////////////////////

  task automatic write_word(input int idx, input logic [63:0] w);
    @(negedge clk);
    itcm_wr_en   = 1'b1;
    itcm_wr_addr = idx[itcm_aw-4:0];
    itcm_wr_data = w;
    model_mem[idx] = w;
    @(negedge clk);
    itcm_wr_en = 1'b0;
  endtask

  task automatic load_itcm();
    logic [63:0] w;
    for (int i = 0; i < words; i++) begin
      draw_word(w);
      write_word(i, w);
    end
  endtask

  task automatic start_fetch(input logic [pc_size-1:0] pc);
    @(negedge clk);
    redirect_valid = 1'b1;
    redirect_pc    = pc;
    fetch_en       = 1'b1;
    @(negedge clk);
    redirect_valid = 1'b0;
  endtask

  // Drop fetch_en once the final PC is on offer so it is the last request
  task automatic pause_after(input logic [pc_size-1:0] last_pc);
    while (!(uut.req_valid && uut.req.pc == last_pc)) @(negedge clk);
    fetch_en = 1'b0;
  endtask

  // Wait for n entries out and then for generator, bridge and buffer to drain
  task automatic wait_done(input int n);
    while (got_q.size() < n) @(negedge clk);
    while (uut.req_valid || !uut.u_ift2icb.sta_idle || out_valid) @(negedge clk);
  endtask

  task automatic run_stream(input logic [pc_size-1:0] start_pc, input int n, input string tag);
    start_fetch(start_pc);
    pause_after(start_pc + pc_size'(4 * (n - 1)));
    wait_done(n);
    check_stream(start_pc, n, tag);
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////

  task automatic test_aligned_seq();
    run_stream(32'h100, 16, "aligned");
  endtask

  // Offsets alternate 01 and 11
  task automatic test_halfword_start();
    run_stream(32'h182, 12, "halfword");
    for (int i = 0; i < last_q.size(); i++) begin
      check_val($sformatf("halfword alternating err[%0d]", i), i % 2, last_q[i].err);
    end
  endtask

  task automatic test_holdup_vs_nohold();
    itcm_nohold = 1'b0;
    run_stream(32'h300, 12, "holdup");
    saved_q = last_q;
    itcm_nohold = 1'b1;
    run_stream(32'h300, 12, "nohold");
    check_val("nohold entry count", saved_q.size(), last_q.size());
    for (int i = 0; i < saved_q.size() && i < last_q.size(); i++) begin
      check_val($sformatf("nohold instr[%0d]", i), saved_q[i].instr, last_q[i].instr);
      check_val($sformatf("nohold err[%0d]", i), saved_q[i].err, last_q[i].err);
    end
    itcm_nohold = 1'b0;
  endtask

  // Pause right after 0x410 so the next fetch 0x414 would reuse the held lane
  task automatic test_write_breaks_holdup();
    logic [63:0] new_word;
    int          idx;
    run_stream(32'h400, 5, "pre-write");
    idx      = 32'h414 >> 3;
    // Every bit flips so stale data cannot match
    new_word = ~model_mem[idx];
    write_word(idx, new_word);
    @(negedge clk);
    fetch_en = 1'b1;
    pause_after(32'h414 + 32'd20);
    wait_done(6);
    check_stream(32'h414, 6, "post-write");
    if (last_q.size() > 0) begin
      check_val("post-write first instr", new_word[63:32], last_q[0].instr);
    end
  endtask

  task automatic test_back_pressure();
    logic seen;
    seen      = 1'b0;
    out_ready = 1'b0;
    start_fetch(32'h500);
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      // Once queued, entries stay visible
      if (seen) check_val("out_valid during stall", 1, out_valid);
      if (out_valid) seen = 1'b1;
    end
    check_val("out_valid at end of stall", 1, out_valid);
    check_val("entries taken during stall", 0, got_q.size());
    out_ready = 1'b1;
    pause_after(32'h500 + 32'd44);
    wait_done(12);
    check_stream(32'h500, 12, "backpressure");
  endtask

  //////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////

  initial begin
    clk            = 1'b0;
    rst            = 1'b1;
    fetch_en       = 1'b0;
    redirect_valid = 1'b0;
    redirect_pc    = '0;
    itcm_nohold    = 1'b0;
    itcm_wr_en     = 1'b0;
    itcm_wr_addr   = '0;
    itcm_wr_data   = '0;
    out_ready      = 1'b1;
    repeat (rst_cycles) @(negedge clk);
    rst = 1'b0;

    load_itcm();
    test_aligned_seq();
    test_halfword_start();
    test_holdup_vs_nohold();
    test_write_breaks_holdup();
    test_back_pressure();

    sva_fails = uut.u_ift2icb.u_fetch_sva.fail_cnt;
    $display("Checks %0d, errors %0d, assertion failures %0d", check_cnt, err_cnt, sva_fails);
    if (err_cnt == 0 && sva_fails == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
design/ifu_pkg.sv
design/ifu_pc_gen.sv
design/ifu_ift2icb.sv
design/itcm_ctrl.sv
design/ifu_instr_buf.sv
design/ifu_fetch_top.sv
dv/fetch_sva.sv
dv/fetch_tb.sv
